/* Bender.yml */
package:
  name: clear_sync

sources:
  - src/clear_sync_pkg.sv
  - src/phase_cdc_src.sv
  - src/phase_cdc_dst.sv
  - src/clear_initiator.sv
  - src/clear_receiver.sv
  - src/clear_sync_half.sv
  - src/clear_sync.sv
  - target: test
    files:
      - tests/clear_sync_checker.sv
      - tests/clear_sync_tb.sv

/* sim.f */
src/clear_sync_pkg.sv
src/phase_cdc_src.sv
src/phase_cdc_dst.sv
src/clear_initiator.sv
src/clear_receiver.sv
src/clear_sync_half.sv
src/clear_sync.sv
tests/clear_sync_checker.sv
tests/clear_sync_tb.sv

/* src/clear_initiator.sv */
// initiator FSM that walks a locally started clear sequence through its phases
`timescale 1ns/1ps

module clear_initiator import clear_sync_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  logic         isolate_ack_i,
  output clear_phase_e phase_o,
  output logic         valid_o,
  output logic         isolate_o,
  output logic         clear_o,
  input  logic         ready_i
);

  initiator_state_e state_d;
  initiator_state_e state_q;

  // --------------------------------------------------
  // next state and outputs
  // --------------------------------------------------

  always_comb begin
    state_d   = state_q;
    phase_o   = PHASE_IDLE;
    valid_o   = 1'b0;
    isolate_o = 1'b0;
    clear_o   = 1'b0;

    case (state_q)
      ST_IDLE: begin
        if (clear_i) begin
          state_d = ST_ISOLATE;
        end
      end

      // isolate goes out locally and to the other side at the same time
      // both the crossing and the local user have to confirm before we clear
      ST_ISOLATE: begin
        phase_o   = PHASE_ISOLATE;
        valid_o   = 1'b1;
        isolate_o = 1'b1;
        if (ready_i && isolate_ack_i) begin
          state_d = ST_CLEAR;
        end else if (ready_i) begin
          state_d = ST_WAIT_ISOLATE_ACK;
        end else if (isolate_ack_i) begin
          state_d = ST_WAIT_PHASE_ACK;
        end
      end

      // local side is frozen, the other side has not confirmed yet
      ST_WAIT_PHASE_ACK: begin
        phase_o   = PHASE_ISOLATE;
        valid_o   = 1'b1;
        isolate_o = 1'b1;
        if (ready_i) begin
          state_d = ST_CLEAR;
        end
      end

      // other side confirmed, the crossing is idle while we wait
      ST_WAIT_ISOLATE_ACK: begin
        phase_o   = PHASE_ISOLATE;
        isolate_o = 1'b1;
        if (isolate_ack_i) begin
          state_d = ST_CLEAR;
        end
      end

      // clear is held until the other side has seen the clear phase
      ST_CLEAR: begin
        phase_o   = PHASE_CLEAR;
        valid_o   = 1'b1;
        isolate_o = 1'b1;
        clear_o   = 1'b1;
        if (ready_i) begin
          state_d = ST_POST_CLEAR;
        end
      end

      ST_POST_CLEAR: begin
        phase_o   = PHASE_POST_CLEAR;
        valid_o   = 1'b1;
        isolate_o = 1'b1;
        if (ready_i) begin
          state_d = ST_FINISHED;
        end
      end

      // isolation is only released once the other side is back to idle
      ST_FINISHED: begin
        phase_o   = PHASE_IDLE;
        valid_o   = 1'b1;
        isolate_o = 1'b1;
        if (ready_i) begin
          state_d = ST_IDLE;
        end
      end

      default: begin
        state_d = ST_ISOLATE;
      end
    endcase
  end

  // --------------------------------------------------
  // state register
  // --------------------------------------------------

  // a reset is itself a clear event, so it lands in the first phase of a sequence
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_ISOLATE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* src/clear_receiver.sv */
// receiver that follows the other side's sequence and drives local isolate and clear
`timescale 1ns/1ps

module clear_receiver import clear_sync_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         isolate_ack_i,
  input  clear_phase_e phase_i,
  input  logic         valid_i,
  output logic         ready_o,
  output logic         isolate_o,
  output logic         clear_o
);

  clear_phase_e phase_q;
  clear_phase_e cur_phase;

  // --------------------------------------------------
  // accepted phase
  // --------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= PHASE_IDLE;
    end else if (valid_i && ready_o) begin
      phase_q <= phase_i;
    end
  end

  // an incoming phase acts in the cycle it shows up, even before it is accepted
  assign cur_phase = valid_i ? phase_i : phase_q;

  // --------------------------------------------------
  // outputs and acceptance
  // --------------------------------------------------

  always_comb begin
    isolate_o = 1'b0;
    clear_o   = 1'b0;
    ready_o   = 1'b0;

    case (cur_phase)
      PHASE_IDLE: begin
        ready_o = valid_i;
      end

      // the other side may only move on once our user has frozen its side
      PHASE_ISOLATE: begin
        isolate_o = 1'b1;
        ready_o   = valid_i && isolate_ack_i;
      end

      PHASE_CLEAR: begin
        isolate_o = 1'b1;
        clear_o   = 1'b1;
        ready_o   = valid_i;
      end

      PHASE_POST_CLEAR: begin
        isolate_o = 1'b1;
        ready_o   = valid_i;
      end

      default: begin
        ready_o = 1'b0;
      end
    endcase
  end

endmodule

/* src/clear_sync.sv */
// top level with two mirrored clear synchronizer halves joined by phase crossings
`timescale 1ns/1ps

module clear_sync import clear_sync_pkg::*; (
  // side A
  input  logic a_clk_i,
  input  logic a_rst_ni,
  input  logic a_clear_i,
  input  logic a_isolate_ack_i,
  output logic a_clear_o,
  output logic a_isolate_o,
  // side B
  input  logic b_clk_i,
  input  logic b_rst_ni,
  input  logic b_clear_i,
  input  logic b_isolate_ack_i,
  output logic b_clear_o,
  output logic b_isolate_o
);

  // --------------------------------------------------
  // crossing wires
  // --------------------------------------------------

  // these nets cross clock domains and are only sampled through synchronizers
  phase_msg_t a2b_msg;
  phase_msg_t b2a_msg;
  logic       a2b_ack;
  logic       b2a_ack;

  // side A sends a2b_msg and gets its ack back on b2a_ack
  clear_sync_half half_a_inst (
    .clk_i         (a_clk_i),
    .rst_ni        (a_rst_ni),
    .clear_i       (a_clear_i),
    .isolate_ack_i (a_isolate_ack_i),
    .clear_o       (a_clear_o),
    .isolate_o     (a_isolate_o),
    .msg_o         (a2b_msg),
    .ack_i         (b2a_ack),
    .msg_i         (b2a_msg),
    .ack_o         (a2b_ack)
  );

  // side B is the exact mirror
  clear_sync_half half_b_inst (
    .clk_i         (b_clk_i),
    .rst_ni        (b_rst_ni),
    .clear_i       (b_clear_i),
    .isolate_ack_i (b_isolate_ack_i),
    .clear_o       (b_clear_o),
    .isolate_o     (b_isolate_o),
    .msg_o         (b2a_msg),
    .ack_i         (a2b_ack),
    .msg_i         (a2b_msg),
    .ack_o         (b2a_ack)
  );

endmodule

/* src/clear_sync_half.sv */
// one domain's half with initiator, receiver, both crossing ends and the output merge
`timescale 1ns/1ps

module clear_sync_half import clear_sync_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  logic       isolate_ack_i,
  output logic       clear_o,
  output logic       isolate_o,
  // our sequence toward the other side
  output phase_msg_t msg_o,
  input  logic       ack_i,
  // the other side's sequence toward us
  input  phase_msg_t msg_i,
  output logic       ack_o
);

  clear_phase_e init_phase;
  logic         init_valid;
  logic         init_ready;
  logic         init_isolate;
  logic         init_clear;

  clear_phase_e recv_phase;
  logic         recv_valid;
  logic         recv_ready;
  logic         recv_isolate;
  logic         recv_clear;

  // --------------------------------------------------
  // initiator path
  // --------------------------------------------------

  clear_initiator clear_initiator_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .isolate_ack_i (isolate_ack_i),
    .phase_o       (init_phase),
    .valid_o       (init_valid),
    .isolate_o     (init_isolate),
    .clear_o       (init_clear),
    .ready_i       (init_ready)
  );

  phase_cdc_src phase_cdc_src_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .phase_i (init_phase),
    .valid_i (init_valid),
    .ready_o (init_ready),
    .msg_o   (msg_o),
    .ack_i   (ack_i)
  );

  // --------------------------------------------------
  // receiver path
  // --------------------------------------------------

  phase_cdc_dst phase_cdc_dst_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .msg_i   (msg_i),
    .ack_o   (ack_o),
    .phase_o (recv_phase),
    .valid_o (recv_valid),
    .ready_i (recv_ready)
  );

  clear_receiver clear_receiver_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .isolate_ack_i (isolate_ack_i),
    .phase_i       (recv_phase),
    .valid_i       (recv_valid),
    .ready_o       (recv_ready),
    .isolate_o     (recv_isolate),
    .clear_o       (recv_clear)
  );

  // both sequences may run at once, so either one can hold the local side
  assign clear_o   = init_clear | recv_clear;
  assign isolate_o = init_isolate | recv_isolate;

endmodule

/* src/clear_sync_pkg.sv */
// package with phase and state enums, phase message struct and crossing constants
package clear_sync_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------

  typedef logic [1:0] phase_bits_t;
  typedef logic [2:0] state_bits_t;

  // --------------------------------------------------
  // phase of a clear sequence as sent across the CDC
  // --------------------------------------------------

  typedef enum phase_bits_t {
    PHASE_IDLE       = 2'd0,
    PHASE_ISOLATE    = 2'd1,
    PHASE_CLEAR      = 2'd2,
    PHASE_POST_CLEAR = 2'd3
  } clear_phase_e;

  // states of the initiator FSM
  typedef enum state_bits_t {
    ST_IDLE             = 3'd0,
    ST_ISOLATE          = 3'd1,
    ST_WAIT_PHASE_ACK   = 3'd2,
    ST_WAIT_ISOLATE_ACK = 3'd3,
    ST_CLEAR            = 3'd4,
    ST_POST_CLEAR       = 3'd5,
    ST_FINISHED         = 3'd6
  } initiator_state_e;

  // forward wires of one crossing direction whose phase is held stable while req is high
  typedef struct packed {
    logic         req;
    clear_phase_e phase;
  } phase_msg_t;

  // synchronizer depth on both req and ack paths
  localparam int unsigned sync_stages = 2;

  // an async reset announces itself to the other side with this phase
  localparam clear_phase_e reset_phase = PHASE_ISOLATE;

endpackage

/* src/phase_cdc_dst.sv */
// receiving end of the four-phase phase crossing with its req synchronizer
`timescale 1ns/1ps

module phase_cdc_dst import clear_sync_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  phase_msg_t   msg_i,
  output logic         ack_o,
  output clear_phase_e phase_o,
  output logic         valid_o,
  input  logic         ready_i
);

  logic [sync_stages-1:0] req_sync_q;
  logic                   req_synced;
  logic                   ack_q;

  // --------------------------------------------------
  // req synchronizer
  // --------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_sync_q <= '0;
    end else begin
      req_sync_q <= {req_sync_q[sync_stages-2:0], msg_i.req};
    end
  end

  assign req_synced = req_sync_q[sync_stages-1];

  // --------------------------------------------------
  // ack generation
  // --------------------------------------------------

  // ack rises on local acceptance and stays up until the source drops req
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else if (!ack_q) begin
      if (req_synced && ready_i) begin
        ack_q <= 1'b1;
      end
    end else if (!req_synced) begin
      ack_q <= 1'b0;
    end
  end

  // the phase wires are held while req is high
  // and have settled by the time req comes through the synchronizer
  assign phase_o = msg_i.phase;

  // offer each phase once, not again while we wait for req to fall
  assign valid_o = req_synced && !ack_q;

  assign ack_o = ack_q;

endmodule

/* src/phase_cdc_src.sv */
// sending end of the four-phase phase crossing with its ack synchronizer
`timescale 1ns/1ps

module phase_cdc_src import clear_sync_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  clear_phase_e phase_i,
  input  logic         valid_i,
  output logic         ready_o,
  output phase_msg_t   msg_o,
  input  logic         ack_i
);

  logic [sync_stages-1:0] ack_sync_q;
  logic                   ack_synced;
  logic                   req_q;
  logic                   busy_q;
  clear_phase_e           phase_q;

  // --------------------------------------------------
  // ack synchronizer
  // --------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_sync_q <= '0;
    end else begin
      ack_sync_q <= {ack_sync_q[sync_stages-2:0], ack_i};
    end
  end

  assign ack_synced = ack_sync_q[sync_stages-1];

  // --------------------------------------------------
  // req / phase handshake
  // --------------------------------------------------

  // busy covers the whole round trip, req only its first half
  // out of reset we are already mid-transfer with the reset phase on the wires
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q   <= 1'b1;
      busy_q  <= 1'b1;
      phase_q <= reset_phase;
    end else if (!busy_q) begin
      // a stale ack from before a one-sided reset must drain before a new req
      if (valid_i && !ack_synced) begin
        req_q   <= 1'b1;
        busy_q  <= 1'b1;
        phase_q <= phase_i;
      end
    end else if (req_q) begin
      if (ack_synced) begin
        req_q <= 1'b0;
      end
    end else if (!ack_synced) begin
      busy_q <= 1'b0;
    end
  end

  // the step only counts as done once ack has fallen again
  assign ready_o = busy_q && !req_q && !ack_synced;

  assign msg_o.req   = req_q;
  assign msg_o.phase = phase_q;

endmodule

/* tests/clear_sync_checker.sv */
// checker for both sides of the clear synchronizer and its per-side monitor
`timescale 1ns/1ps

module side_monitor #(
  parameter side_name = "a"
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  logic        isolate_i,
  input  logic        ack_i,
  input  logic        other_ack_i,
  output int unsigned pulses_o,
  output int unsigned errors_o,
  output int unsigned checks_o
);

  int unsigned pulses_q  = 0;
  int unsigned errors_q  = 0;
  int unsigned checks_q  = 0;
  logic        clear_q   = 1'b0;
  logic        isolate_q = 1'b0;

  // outputs of this side settle half a cycle before the falling edge
  always @(negedge clk_i) begin
    checks_q = checks_q + 1;
    if (!rst_ni) begin
      // a reset starts a sequence, so the side must be isolated and not cleared
      if (isolate_i !== 1'b1 || clear_i !== 1'b0) begin
        $display("error: in reset %s_isolate_o = %h, %s_clear_o = %h at %0t",
                 side_name, isolate_i, side_name, clear_i, $time);
        errors_q = errors_q + 1;
      end
    end else begin
      if (clear_i === 1'b1 && isolate_i !== 1'b1) begin
        $display("error: %s_clear_o = %h while %s_isolate_o = %h at %0t",
                 side_name, clear_i, side_name, isolate_i, $time);
        errors_q = errors_q + 1;
      end
      // clear may only start once both users have frozen their side
      if (clear_i === 1'b1 && clear_q !== 1'b1) begin
        pulses_q = pulses_q + 1;
        if (ack_i !== 1'b1 || other_ack_i !== 1'b1) begin
          $display("error: %s_clear_o rose with isolate acks own = %h, other = %h at %0t",
                   side_name, ack_i, other_ack_i, $time);
          errors_q = errors_q + 1;
        end
        // isolate has to lead clear by at least one cycle
        if (isolate_q !== 1'b1) begin
          $display("error: %s_clear_o rose with %s_isolate_o = %h one cycle earlier at %0t",
                   side_name, side_name, isolate_q, $time);
          errors_q = errors_q + 1;
        end
      end
    end
    clear_q   = clear_i;
    isolate_q = isolate_i;
  end

  assign pulses_o = pulses_q;
  assign errors_o = errors_q;
  assign checks_o = checks_q;

endmodule

module clear_sync_checker (
  input  logic        a_clk_i,
  input  logic        a_rst_ni,
  input  logic        a_isolate_ack_i,
  input  logic        a_clear_out_i,
  input  logic        a_isolate_out_i,
  input  logic        b_clk_i,
  input  logic        b_rst_ni,
  input  logic        b_isolate_ack_i,
  input  logic        b_clear_out_i,
  input  logic        b_isolate_out_i,
  input  logic        row_end_i,
  input  logic [3:0]  exp_min_i,
  input  logic [3:0]  exp_max_i,
  output int unsigned errors_o,
  output int unsigned checks_o
);

  int unsigned a_pulses;
  int unsigned b_pulses;
  int unsigned a_errors;
  int unsigned b_errors;
  int unsigned a_checks;
  int unsigned b_checks;
  int unsigned a_base       = 0;
  int unsigned b_base       = 0;
  int unsigned count_errors = 0;
  int unsigned count_checks = 0;

  side_monitor #(.side_name("a")) a_monitor_inst (
    .clk_i       (a_clk_i),
    .rst_ni      (a_rst_ni),
    .clear_i     (a_clear_out_i),
    .isolate_i   (a_isolate_out_i),
    .ack_i       (a_isolate_ack_i),
    .other_ack_i (b_isolate_ack_i),
    .pulses_o    (a_pulses),
    .errors_o    (a_errors),
    .checks_o    (a_checks)
  );

  side_monitor #(.side_name("b")) b_monitor_inst (
    .clk_i       (b_clk_i),
    .rst_ni      (b_rst_ni),
    .clear_i     (b_clear_out_i),
    .isolate_i   (b_isolate_out_i),
    .ack_i       (b_isolate_ack_i),
    .other_ack_i (a_isolate_ack_i),
    .pulses_o    (b_pulses),
    .errors_o    (b_errors),
    .checks_o    (b_checks)
  );

  // --------------------------------------------------
  // clear pulses per table row
  // --------------------------------------------------

  task automatic check_pulses(input string side, input int unsigned got,
                              input logic [3:0] lo, input logic [3:0] hi);
    count_checks = count_checks + 1;
    if (got < lo || got > hi) begin
      $display("error: %s_clear_o pulses = %h, expected %h to %h", side, got, lo, hi);
      count_errors = count_errors + 1;
    end
  endtask

  // pulse counters only move on falling edges, so they are steady here
  always @(posedge a_clk_i) begin
    if (row_end_i) begin
      check_pulses("a", a_pulses - a_base, exp_min_i, exp_max_i);
      check_pulses("b", b_pulses - b_base, exp_min_i, exp_max_i);
      a_base = a_pulses;
      b_base = b_pulses;
    end
  end

  assign errors_o = a_errors + b_errors + count_errors;
  assign checks_o = a_checks + b_checks + count_checks;

endmodule

/* tests/clear_sync_tb.sv */
// testbench top with clocks, resets, stimulus table, isolate acknowledge models and watchdog
`timescale 1ns/1ps

module clear_sync_tb;

  typedef enum logic [2:0] {
    ACT_CLEAR_A,
    ACT_CLEAR_B,
    ACT_CLEAR_BOTH,
    ACT_RESET_A,
    ACT_RESET_B
  } action_e;

  // each table row holds the action, how long each user stays unfrozen and the clear pulses
  // expected per side
  typedef struct packed {
    action_e    action;
    logic [7:0] a_hold;
    logic [7:0] b_hold;
    logic [3:0] exp_min;
    logic [3:0] exp_max;
  } row_t;

  localparam int num_rows       = 8;
  localparam int cycles_per_row = 400;

  logic        a_clk;
  logic        a_rst_n;
  logic        a_clear_req;
  logic        a_iso_ack;
  logic        a_clear;
  logic        a_isolate;
  logic        b_clk;
  logic        b_rst_n;
  logic        b_clear_req;
  logic        b_iso_ack;
  logic        b_clear;
  logic        b_isolate;
  logic        row_end;
  logic [3:0]  exp_min;
  logic [3:0]  exp_max;
  int unsigned a_ack_delay;
  int unsigned b_ack_delay;
  int unsigned a_ack_cnt;
  int unsigned b_ack_cnt;
  int unsigned errors;
  int unsigned checks;
  row_t        rows [num_rows];

  clear_sync clear_sync_inst (
    .a_clk_i         (a_clk),
    .a_rst_ni        (a_rst_n),
    .a_clear_i       (a_clear_req),
    .a_isolate_ack_i (a_iso_ack),
    .a_clear_o       (a_clear),
    .a_isolate_o     (a_isolate),
    .b_clk_i         (b_clk),
    .b_rst_ni        (b_rst_n),
    .b_clear_i       (b_clear_req),
    .b_isolate_ack_i (b_iso_ack),
    .b_clear_o       (b_clear),
    .b_isolate_o     (b_isolate)
  );

  clear_sync_checker clear_sync_checker_inst (
    .a_clk_i         (a_clk),
    .a_rst_ni        (a_rst_n),
    .a_isolate_ack_i (a_iso_ack),
    .a_clear_out_i   (a_clear),
    .a_isolate_out_i (a_isolate),
    .b_clk_i         (b_clk),
    .b_rst_ni        (b_rst_n),
    .b_isolate_ack_i (b_iso_ack),
    .b_clear_out_i   (b_clear),
    .b_isolate_out_i (b_isolate),
    .row_end_i       (row_end),
    .exp_min_i       (exp_min),
    .exp_max_i       (exp_max),
    .errors_o        (errors),
    .checks_o        (checks)
  );

  // --------------------------------------------------
  // clocks and user models
  // --------------------------------------------------

  always begin
    #20 a_clk = ~a_clk;
  end

  // side B runs at the same rate but 13 ns behind side A
  always begin
    #13;
    forever begin
      #20 b_clk = ~b_clk;
    end
  end

  // each user freezes its side a few cycles after isolate rises and unfreezes with it
  always @(posedge a_clk) begin
    #1;
    if (!a_isolate) begin
      a_ack_cnt = 0;
      a_iso_ack = 1'b0;
    end else if (a_ack_cnt >= a_ack_delay) begin
      a_iso_ack = 1'b1;
    end else begin
      a_ack_cnt = a_ack_cnt + 1;
    end
  end

  always @(posedge b_clk) begin
    #1;
    if (!b_isolate) begin
      b_ack_cnt = 0;
      b_iso_ack = 1'b0;
    end else if (b_ack_cnt >= b_ack_delay) begin
      b_iso_ack = 1'b1;
    end else begin
      b_ack_cnt = b_ack_cnt + 1;
    end
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  function automatic row_t make_row(input action_e action, input logic [7:0] a_hold,
                                    input logic [7:0] b_hold, input logic [3:0] lo,
                                    input logic [3:0] hi);
    row_t r;
    r.action  = action;
    r.a_hold  = a_hold;
    r.b_hold  = b_hold;
    r.exp_min = lo;
    r.exp_max = hi;
    return r;
  endfunction

  // a clear request lasts one cycle, a one-sided reset four
  task automatic apply_action(input action_e action);
    case (action)
      ACT_CLEAR_A: a_clear_req = 1'b1;
      ACT_CLEAR_B: b_clear_req = 1'b1;
      ACT_CLEAR_BOTH: begin
        a_clear_req = 1'b1;
        b_clear_req = 1'b1;
      end
      ACT_RESET_A: a_rst_n = 1'b0;
      default: b_rst_n = 1'b0;
    endcase
    @(posedge a_clk);
    #1;
    a_clear_req = 1'b0;
    b_clear_req = 1'b0;
    repeat (3) @(posedge a_clk);
    #1;
    a_rst_n = 1'b1;
    b_rst_n = 1'b1;
  endtask

  // a sequence is over once both isolates are low again
  task automatic wait_for_idle();
    @(negedge a_clk);
    while (!a_isolate && !b_isolate) @(negedge a_clk);
    while (a_isolate || b_isolate) @(negedge a_clk);
    repeat (4) @(negedge a_clk);
  endtask

  task automatic close_row(input logic [3:0] lo, input logic [3:0] hi);
    @(posedge a_clk);
    #1;
    exp_min = lo;
    exp_max = hi;
    row_end = 1'b1;
    @(posedge a_clk);
    #1;
    row_end = 1'b0;
  endtask

  // --------------------------------------------------
  // main sequence and watchdog
  // --------------------------------------------------

  initial begin
    void'($urandom(20825));
    a_clk       = 1'b0;
    b_clk       = 1'b0;
    a_rst_n     = 1'b1;
    b_rst_n     = 1'b1;
    a_clear_req = 1'b0;
    b_clear_req = 1'b0;
    a_iso_ack   = 1'b0;
    b_iso_ack   = 1'b0;
    a_ack_delay = 0;
    b_ack_delay = 0;
    a_ack_cnt   = 0;
    b_ack_cnt   = 0;
    row_end     = 1'b0;
    exp_min     = 4'd0;
    exp_max     = 4'd0;
    rows[0] = make_row(ACT_CLEAR_A,    8'd0,  8'd0,  4'd1, 4'd1);
    rows[1] = make_row(ACT_CLEAR_B,    8'd1,  8'd0,  4'd1, 4'd1);
    rows[2] = make_row(ACT_CLEAR_A,    8'd0,  8'd20, 4'd1, 4'd1);
    rows[3] = make_row(ACT_CLEAR_B,    8'd12, 8'd0,  4'd1, 4'd1);
    rows[4] = make_row(ACT_CLEAR_BOTH, 8'd0,  8'd0,  4'd1, 4'd2);
    rows[5] = make_row(ACT_CLEAR_BOTH, 8'd3,  8'd1,  4'd1, 4'd2);
    rows[6] = make_row(ACT_RESET_A,    8'd0,  8'd0,  4'd1, 4'd1);
    rows[7] = make_row(ACT_RESET_B,    8'd2,  8'd0,  4'd1, 4'd1);
    #1;
    a_rst_n = 1'b0;
    b_rst_n = 1'b0;
    // each side leaves reset after eight of its own clock cycles
    fork
      begin
        repeat (8) @(posedge a_clk);
        #1;
        a_rst_n = 1'b1;
      end
      begin
        repeat (8) @(posedge b_clk);
        #1;
        b_rst_n = 1'b1;
      end
    join
    // the reset itself runs one sequence on both sides
    wait_for_idle();
    close_row(4'd1, 4'd1);
    for (int i = 0; i < num_rows; i++) begin
      @(posedge a_clk);
      #1;
      a_ack_delay = rows[i].a_hold + ($urandom % 4);
      b_ack_delay = rows[i].b_hold + ($urandom % 4);
      apply_action(rows[i].action);
      wait_for_idle();
      close_row(rows[i].exp_min, rows[i].exp_max);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    repeat ((num_rows + 1) * cycles_per_row) @(posedge a_clk);
    $display("timeout: the clear sequences did not finish in %0d cycles",
             (num_rows + 1) * cycles_per_row);
    $display("sim failed");
    $finish;
  end

endmodule
